/* tests/mem_dump_vectors.txt */
# W width(0 byte 1 half 2 word) addr(hex) data(hex) error(0 ENONE 1 EALIGN 2 ERANGE)
# S start, I start that a running dump ignores, D expected frame word (hex), E wait for done
W 2 20 11223344 0
W 2 24 55667788 0
W 2 28 99aabbcc 0
W 2 2c ddeeff00 0
W 2 30 01234567 0
W 2 34 89abcdef 0
W 2 38 cafef00d 0
W 2 3c 0badc0de 0
W 0 21 000000a5 0
W 1 26 0000beef 0
W 0 2b 0000007e 0
W 1 2c 00001234 0
W 1 31 0000ffff 1
W 2 36 ffffffff 1
W 2 100 deadbeef 2
W 0 1ff 000000aa 2
S
D 1122a544
D beef7788
D 7eaabbcc
D ddee1234
D 01234567
D 89abcdef
D cafef00d
D 0badc0de
E
W 2 30 a5a5a5a5 0
W 0 3f 00000011 0
S
D 1122a544
D beef7788
D 7eaabbcc
I
D ddee1234
D a5a5a5a5
D 89abcdef
D cafef00d
D 11adc0de
E

/* verilog.f */
logic/mem_pkg.sv
logic/spi_pkg.sv
logic/data_mem.sv
logic/mem_send_ctrl.sv
logic/spi_master_w.sv
logic/mem_dump_top.sv
tests/mem_dump_checker.sv
tests/mem_dump_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory dump testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Could not enter the project directory"
    exit 1
fi

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mem_dump_tb \
    -Mdir "$build_dir" -o mem_dump_sim \
    -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/mem_dump_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '*** PASSED ***' "$log_file"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* tests/mem_dump_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_dump_tb import mem_pkg::*; ();

    localparam int start_addr    = 32;
    localparam int end_addr      = 60;
    localparam int frame_count   = (end_addr - start_addr) / 4 + 1;
    localparam int frame_timeout = 1000;
    localparam int done_timeout  = 1000;
    localparam int quiet_cycles  = 300;

    logic                  clk;
    logic                  rst;
    logic                  wr_en;
    mem_dt_e               wr_dt;
    logic [word_width-1:0] wr_addr;
    logic [word_width-1:0] wr_data;
    errno_e                wr_err;
    logic                  start;
    logic                  done;
    logic                  mosi;
    logic                  ss;
    logic                  sck;

    logic [word_width-1:0] frames [$]; // Words decoded from mosi in arrival order
    logic [word_width-1:0] rx_word;
    int                    rx_bits;
    int                    rx_frames; // Frames the monitor saw since the last fresh start
    logic                  sck_q;
    logic                  sck_rise;
    int                    pass_frames;

    mem_dump_top #(
        .mem_words(64),
        .start_addr(start_addr),
        .end_addr(end_addr),
        .sck_width_clks(2)
    ) dut (
        .clk(clk),
        .rst(rst),
        .wr_en(wr_en),
        .wr_dt(wr_dt),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_err(wr_err),
        .start(start),
        .done(done),
        .mosi(mosi),
        .ss(ss),
        .sck(sck)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_err(input errno_e got, input errno_e exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %s expected %s",
                     $time, what, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_word(input logic [word_width-1:0] got,
                              input logic [word_width-1:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %h expected %h",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic write_mem(input mem_dt_e dt, input logic [word_width-1:0] addr,
                             input logic [word_width-1:0] data, input errno_e exp_err);
        wr_en = 1'b1;
        wr_dt = dt;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        check_err(wr_err, exp_err, $sformatf("wr_err of %s write to %h", dt.name(), addr));
    endtask

    task automatic pulse_start(input logic fresh);
        if (fresh) begin
            pass_frames = 0; // A strobe during a dump does not open a new pass
            rx_frames = 0;
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic expect_frame(input logic [word_width-1:0] exp);
        int waited;
        waited = 0;
        while (frames.size() == 0 && waited < frame_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (frames.size() == 0) begin
            $display("Timeout: no SPI frame arrived within %0d clock cycles", frame_timeout);
            abort_run();
        end else begin
            pass_frames++;
            check_word(frames.pop_front(), exp, $sformatf("frame %0d of the dump", pass_frames));
        end
    endtask

    task automatic finish_dump();
        int waited;
        int i;
        waited = 0;
        while (!done && waited < done_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d clock cycles", done_timeout);
            abort_run();
        end else begin
            check_flag(ss, 1'b1, "ss when done is high");
            check_count(rx_frames, frame_count, "frames sent before done");
            for (i = 0; i < quiet_cycles; i++) begin
                @(posedge clk);
                #1;
                check_flag(ss, 1'b1, "ss after the dump has finished");
            end
            check_count(frames.size(), 0, "frames after done");
        end
    endtask

    // The SPI monitor samples at the falling clock edge where the pins are settled
    always @(negedge clk) begin
        if (rst) begin
            rx_bits = 0;
            sck_q = 1'b0;
        end else begin
            sck_rise = !ss && sck && !sck_q;
            sck_q = sck;
            if (ss && rx_bits != 0) begin
                $display("An SPI frame ended after %0d of %0d bits", rx_bits, word_width);
                abort_run();
            end else if (sck_rise) begin
                rx_word = {rx_word[word_width-2:0], mosi}; // MSB first
                rx_bits++;
                if (rx_bits == word_width) begin
                    frames.push_back(rx_word);
                    rx_frames++;
                    rx_bits = 0;
                end
            end
        end
    end

    initial begin
        int                    fd;
        int                    n;
        int                    dt_val;
        int                    err_val;
        int                    dumps;
        logic [7:0]            tag;
        logic [word_width-1:0] addr_val;
        logic [word_width-1:0] data_val;
        logic [8*160-1:0]      line;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_dt = MEM_DT_BYTE;
        wr_addr = '0;
        wr_data = '0;
        start = 1'b0;
        pass_frames = 0;
        rx_frames = 0;
        dumps = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag(done, 1'b0, "done after reset");
        check_flag(ss, 1'b1, "ss after reset");
        check_flag(sck, 1'b0, "sck after reset");
        check_flag(mosi, 1'b0, "mosi after reset");
        check_err(wr_err, ENONE, "wr_err after reset");
        fd = $fopen("tests/mem_dump_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/mem_dump_vectors.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                tag = 8'h00;
                n = $fscanf(fd, "%s", tag);
                if (n == 1) begin
                    if (tag == "#") begin
                        n = $fgets(line, fd);
                    end else if (tag == "W") begin
                        n = $fscanf(fd, "%d %h %h %d", dt_val, addr_val, data_val, err_val);
                        if (n != 4) begin
                            $display("A write line in the vector file is incomplete");
                            abort_run();
                        end else begin
                            write_mem(mem_dt_e'(dt_val[1:0]), addr_val, data_val,
                                      errno_e'(err_val[1:0]));
                        end
                    end else if (tag == "S") begin
                        pulse_start(1'b1);
                    end else if (tag == "I") begin
                        pulse_start(1'b0);
                    end else if (tag == "D") begin
                        n = $fscanf(fd, "%h", data_val);
                        expect_frame(data_val);
                    end else if (tag == "E") begin
                        finish_dump();
                        dumps++;
                    end else begin
                        $display("The vector file holds an unknown line type");
                        abort_run();
                    end
                end
            end
            $fclose(fd);
        end
        if (dumps < 2) begin
            $display("The vector file held %0d complete dumps instead of two", dumps);
            abort_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/mem_dump_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_dump_checker (
    input wire clk,
    input wire rst,
    input wire ss,
    input wire sck,
    input wire mosi,
    input wire done
);

    // Mode 0 keeps the clock low whenever no frame is open
    sck_low_when_idle: assert property (@(posedge clk) disable iff (rst)
        ss |-> !sck)
        else $error("sck is high while ss is high");

    mosi_stable_high: assert property (@(posedge clk) disable iff (rst)
        (sck && $past(sck)) |-> $stable(mosi))
        else $error("mosi changed while sck was high");

    done_not_in_frame: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> ss)
        else $error("done rose while ss was low");

    // The frame closes on the falling edge of the last bit
    ss_after_sck_fall: assert property (@(posedge clk) disable iff (rst)
        $rose(ss) |-> $fell(sck))
        else $error("ss rose without sck falling");

endmodule

bind mem_dump_top mem_dump_checker u_checker (
    .clk(clk),
    .rst(rst),
    .ss(ss),
    .sck(sck),
    .mosi(mosi),
    .done(done)
);

`default_nettype wire

/* logic/mem_dump_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_dump_top import mem_pkg::*; #(
    parameter int mem_words      = 64,
    parameter int start_addr     = 32,
    parameter int end_addr       = 60,
    parameter int sck_width_clks = 2
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  wr_en,
    input  wire mem_dt_e         wr_dt,
    input  wire [word_width-1:0] wr_addr,
    input  wire [word_width-1:0] wr_data,
    output errno_e               wr_err,
    input  wire                  start,
    output wire                  done,
    output wire                  mosi,
    output wire                  ss,
    output wire                  sck
);
    wire [word_width-1:0] tm_addr;
    wire [word_width-1:0] tm_rdata;
    wire                  si_en;
    wire                  si_busy;

    data_mem #(
        .mem_words(mem_words)
    ) u_data_mem (
        .clk(clk),
        .rst(rst),
        .wr_en(wr_en),
        .wr_dt(wr_dt),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_err(wr_err),
        .tm_addr(tm_addr),
        .tm_rdata(tm_rdata)
    );

    mem_send_ctrl #(
        .start_addr(start_addr),
        .end_addr(end_addr)
    ) u_mem_send_ctrl (
        .clk(clk),
        .rst(rst),
        .start(start),
        .si_busy(si_busy),
        .si_en(si_en),
        .tm_addr(tm_addr),
        .done(done)
    );

    spi_master_w #(
        .sck_width_clks(sck_width_clks)
    ) u_spi_master_w (
        .clk(clk),
        .rst(rst),
        .si_en(si_en),
        .tx_data(tm_rdata), // Word at tm_addr, read combinationally
        .si_busy(si_busy),
        .mosi(mosi),
        .ss(ss),
        .sck(sck)
    );

endmodule

`default_nettype wire

/* logic/spi_master_w.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_w import mem_pkg::*, spi_pkg::*; #(
    parameter int sck_width_clks = 2
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  si_en,
    input  wire [word_width-1:0] tx_data,
    output logic                 si_busy,
    output logic                 mosi,
    output logic                 ss,
    output logic                 sck
);
    localparam int cnt_w = (sck_width_clks > 1) ? $clog2(sck_width_clks) : 1;
    localparam int bit_w = $clog2(word_width);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(sck_width_clks - 1);
    localparam logic [bit_w-1:0] bit_last  = bit_w'(word_width - 1);

    spi_state_e            cs;
    logic [word_width-1:0] shift_reg;
    logic [bit_w-1:0]      bit_cnt;
    logic [cnt_w-1:0]      clk_cnt;
    logic                  half_done;

    assign half_done = (clk_cnt == half_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= SPI_IDLE;
            shift_reg <= '0;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else begin
            case (cs)
                SPI_IDLE: begin
                    if (si_en) begin
                        cs <= SHIFT_LOW;
                        shift_reg <= tx_data;
                        bit_cnt <= '0;
                        clk_cnt <= '0;
                    end
                end
                SHIFT_LOW: begin
                    if (half_done) begin
                        cs <= SHIFT_HIGH;
                        clk_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                SHIFT_HIGH: begin
                    if (half_done) begin
                        // Falling edge of sck, next bit goes out
                        shift_reg <= {shift_reg[word_width-2:0], 1'b0};
                        clk_cnt <= '0;
                        if (bit_cnt == bit_last) begin
                            cs <= END_GAP;
                        end else begin
                            cs <= SHIFT_LOW;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                END_GAP: begin
                    if (half_done) begin
                        cs <= SPI_IDLE;
                        clk_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: cs <= SPI_IDLE;
            endcase
        end
    end

    // All pins come straight from registers, the register is empty after 32 shifts
    assign mosi = shift_reg[word_width-1];
    assign sck = (cs == SHIFT_HIGH);
    assign ss = (cs == SPI_IDLE) || (cs == END_GAP);
    assign si_busy = (cs != SPI_IDLE); // Covers the end gap too

endmodule

`default_nettype wire

/* logic/mem_send_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_send_ctrl import mem_pkg::*, spi_pkg::*; #(
    parameter int start_addr = 32,
    parameter int end_addr   = 60
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire                   si_busy,
    output logic                  si_en,
    output logic [word_width-1:0] tm_addr,
    output logic                  done
);
    localparam logic [word_width-1:0] first_addr = word_width'(start_addr);
    localparam logic [word_width-1:0] last_addr  = word_width'(end_addr);

    send_state_e           cs;
    logic [word_width-1:0] addr_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= IDLE;
            addr_reg <= first_addr;
        end else begin
            case (cs)
                IDLE, FINISHED: begin
                    if (start) begin // Strobes during a dump are not seen here
                        cs <= SEND_WORD;
                        addr_reg <= first_addr;
                    end
                end
                SEND_WORD: cs <= WAIT_BUSY;
                WAIT_BUSY: begin
                    if (si_busy)
                        cs <= WAIT_WORD;
                end
                WAIT_WORD: begin
                    if (!si_busy) begin
                        if (addr_reg == last_addr) begin
                            cs <= FINISHED;
                        end else begin
                            cs <= SEND_WORD;
                            addr_reg <= addr_reg + word_width'(4);
                        end
                    end
                end
                default: cs <= IDLE;
            endcase
        end
    end

    // The master latches the word while enable is up and it is idle
    assign si_en = (cs == SEND_WORD) || (cs == WAIT_BUSY);
    assign tm_addr = addr_reg;
    assign done = (cs == FINISHED);

endmodule

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import mem_pkg::*; #(
    parameter int mem_words = 64
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wr_en,
    input  wire mem_dt_e          wr_dt,
    input  wire  [word_width-1:0] wr_addr,
    input  wire  [word_width-1:0] wr_data,
    output errno_e                wr_err,
    input  wire  [word_width-1:0] tm_addr,
    output logic [word_width-1:0] tm_rdata
);
    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam logic [word_width-1:0] mem_bytes = word_width'(mem_words * 4);

    logic [word_width-1:0] mem [mem_words];

    logic [3:0]            be;
    logic [word_width-1:0] wdata;
    errno_e                err_next;
    logic [idx_w-1:0]      wr_idx;
    logic [idx_w-1:0]      tm_idx;

    assign wr_idx = wr_addr[idx_w+1:2];
    assign tm_idx = tm_addr[idx_w+1:2];

    always_comb begin
        be = 4'b0000;
        wdata = wr_data;
        err_next = ENONE;
        case (wr_dt)
            MEM_DT_BYTE: begin
                be = 4'b0001 << wr_addr[1:0];
                wdata = {4{wr_data[7:0]}}; // Same byte on every lane, be picks one
            end
            MEM_DT_HALF: begin
                be = 4'b0011 << wr_addr[1:0];
                wdata = {2{wr_data[15:0]}};
                if (wr_addr[0])
                    err_next = EALIGN;
            end
            MEM_DT_WORD: begin
                be = 4'b1111;
                if (wr_addr[1:0] != 2'b00)
                    err_next = EALIGN;
            end
            default: err_next = EALIGN; // Unused encoding is rejected
        endcase
        if (err_next == ENONE && wr_addr >= mem_bytes)
            err_next = ERANGE;
    end

    always_ff @(posedge clk) begin
        if (wr_en && err_next == ENONE) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i])
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_err <= ENONE;
        else if (wr_en)
            wr_err <= err_next; // Held until the next strobe
    end

    // Test-mode read is word granular and returns zero past the end
    assign tm_rdata = (tm_addr < mem_bytes) ? mem[tm_idx] : '0;

endmodule

`default_nettype wire

/* logic/spi_pkg.sv */
`default_nettype none

package spi_pkg;

    // The master's idle state carries a prefix so it does not clash with the controller's IDLE
    typedef enum logic [1:0] {
        SPI_IDLE,
        SHIFT_LOW,
        SHIFT_HIGH,
        END_GAP
    } spi_state_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND_WORD,
        WAIT_BUSY,
        WAIT_WORD,
        FINISHED
    } send_state_e;

endpackage

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Width of a data word and of a byte address
    localparam int word_width = 32;

    // Access width of a load port write
    typedef enum logic [1:0] {
        MEM_DT_BYTE,
        MEM_DT_HALF,
        MEM_DT_WORD
    } mem_dt_e;

    // Outcome of a load port write
    typedef enum logic [1:0] {
        ENONE,  // Write accepted
        EALIGN, // Address not aligned to the access width
        ERANGE  // Address past the end of the memory
    } errno_e;

endpackage

`default_nettype wire
